//--- common/cache_pkg.sv
// shared widths, request structs and FSM states for the icache/dcache subsystem
// import into any module that touches CPU or memory requests
`default_nettype none

package cache_pkg;

    localparam int ADDR_W     = 64;  // byte address
    localparam int OFFSET_W   = 4;   // 16-byte lines
    localparam int LINE_W     = 128;
    localparam int WORD_W     = 64;  // CPU data width
    localparam int BANK_SEL_W = 2;   // top index bits pick the SRAM bank

    // one CPU access, held stable by the core until ready
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [WORD_W-1:0] wdata;
        logic [7:0]        wmask;  // one bit per byte of wdata
        logic              fence;  // dcache only
    } cpu_req_t;

    // one line transfer on the memory port
    typedef struct packed {
        logic [ADDR_W-1:0] addr;   // line aligned
        logic              we;     // write-back when high
        logic [LINE_W-1:0] wdata;
    } mem_req_t;

    // shared by both caches, icache only walks the first four
    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_allocate,
        st_readin,
        st_writeback,
        st_writein,
        st_flush,
        st_flush_next
    } cache_state_e;

endpackage

`default_nettype wire

//--- dcache/dcache.sv
// write-back, write-allocate data cache with byte-masked writes
// a request with fence set walks every set and writes back dirty lines
`timescale 1ns/1ps
`default_nettype none

module dcache
    import cache_pkg::*;
#(
    parameter int INDEX_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  cpu_req_t          req_i,
    input  logic              valid_i,
    output logic [WORD_W-1:0] rdata_o,
    output logic              ready_o,
    output logic              idle_o,
    output mem_req_t          mem_req_o,
    output logic              mem_valid_o,
    input  logic [LINE_W-1:0] mem_rdata_i,
    input  logic              mem_ready_i
);

    localparam int TAG_W  = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NSETS  = 2 ** INDEX_W;
    localparam int NBANKS = 2 ** BANK_SEL_W;
    localparam int RAM_AW = INDEX_W - BANK_SEL_W;
    localparam int DEPTH  = 2 ** RAM_AW;

    cache_state_e state_q, state_d;

    logic [TAG_W-1:0]      tag_q [NSETS];
    logic [NSETS-1:0]      valid_q;
    logic [NSETS-1:0]      dirty_q;
    logic [INDEX_W-1:0]    cnt_q;      // fence walk set
    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    req_idx;
    logic [INDEX_W-1:0]    sram_idx;
    logic [BANK_SEL_W-1:0] bank;
    logic [LINE_W-1:0]     bank_rdata [NBANKS];
    logic [LINE_W-1:0]     line;
    logic [LINE_W-1:0]     byte_en;
    logic [LINE_W-1:0]     merged;
    logic [LINE_W-1:0]     ram_wdata;
    logic                  hit;
    logic                  walking;
    logic                  victim_dirty;
    logic                  flush_dirty;
    logic                  ram_rd;
    logic                  ram_wr;
    logic                  mem_want;

    assign req_tag  = req_i.addr[ADDR_W-1 -: TAG_W];
    assign req_idx  = req_i.addr[OFFSET_W +: INDEX_W];
    assign walking  = (state_q == st_flush) || (state_q == st_flush_next);
    assign sram_idx = walking ? cnt_q : req_idx;
    assign bank     = sram_idx[INDEX_W-1 -: BANK_SEL_W];
    assign line     = bank_rdata[bank];
    assign idle_o   = (state_q == st_idle);

    assign hit          = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
    assign victim_dirty = valid_q[req_idx] && dirty_q[req_idx];
    assign flush_dirty  = valid_q[cnt_q] && dirty_q[cnt_q];

    // wmask lands in the half picked by offset bit 3
    always_comb begin
        for (int b = 0; b < LINE_W / 8; b++) begin
            byte_en[b*8 +: 8] = {8{req_i.wmask[b % 8] && ((b >= 8) == req_i.addr[OFFSET_W-1])}};
        end
    end

    assign merged    = ({2{req_i.wdata}} & byte_en) | (line & ~byte_en);
    assign ram_rd    = (state_q == st_compare) || (state_q == st_flush_next);
    assign ram_wr    = ((state_q == st_allocate) && mem_ready_i) || (state_q == st_writein);
    assign ram_wdata = (state_q == st_writein) ? merged : mem_rdata_i;

    for (genvar g = 0; g < NBANKS; g++) begin : g_bank
        line_sram #(.DEPTH(DEPTH)) u_ram (
            .clk     (clk),
            .en_i    ((ram_rd || ram_wr) && (bank == BANK_SEL_W'(g))),
            .we_i    (ram_wr),
            .addr_i  (sram_idx[RAM_AW-1:0]),
            .wdata_i (ram_wdata),
            .rdata_o (bank_rdata[g])
        );
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (valid_i && !ready_o) state_d = req_i.fence ? st_flush_next : st_compare;
            end
            st_compare: begin
                if (hit) state_d = st_readin;
                else if (victim_dirty) state_d = st_writeback;
                else state_d = st_allocate;
            end
            st_writeback:  if (mem_ready_i) state_d = st_allocate;
            st_allocate:   if (mem_ready_i) state_d = st_compare;
            st_readin:     state_d = req_i.we ? st_writein : st_idle;
            st_writein:    state_d = st_idle;
            st_flush_next: state_d = st_flush;  // line read for cnt_q
            st_flush: begin
                if (!flush_dirty || mem_ready_i) state_d = (&cnt_q) ? st_idle : st_flush_next;
            end
            default: state_d = st_idle;
        endcase
    end

    assign mem_want = (state_q == st_allocate) || (state_q == st_writeback) ||
                      ((state_q == st_flush) && flush_dirty);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= st_idle;
            valid_q     <= '0;
            dirty_q     <= '0;
            cnt_q       <= '0;
            ready_o     <= 1'b0;
            mem_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            ready_o     <= (state_q == st_readin) || (state_q == st_flush && state_d == st_idle);
            mem_valid_o <= mem_want && !mem_ready_i;
            if (state_q == st_idle) cnt_q <= '0;
            else if (state_q == st_flush && state_d == st_flush_next) cnt_q <= cnt_q + 1'b1;
            if (state_q == st_allocate && mem_ready_i) begin
                valid_q[req_idx] <= 1'b1;
                dirty_q[req_idx] <= 1'b0;
            end
            if (state_q == st_writein) dirty_q[req_idx] <= 1'b1;
            if (state_q == st_flush && flush_dirty && mem_ready_i) dirty_q[cnt_q] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_allocate && mem_ready_i) tag_q[req_idx] <= req_tag;
        if (state_q == st_readin && !req_i.we) begin
            rdata_o <= req_i.addr[OFFSET_W-1] ? line[LINE_W-1 -: WORD_W] : line[WORD_W-1:0];
        end
    end

    // victim line comes straight from the bank output, which holds until the next read
    always_comb begin
        mem_req_o.we    = 1'b0;
        mem_req_o.addr  = {req_i.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        mem_req_o.wdata = line;
        if (state_q == st_writeback) begin
            mem_req_o.we   = 1'b1;
            mem_req_o.addr = {tag_q[req_idx], req_idx, {OFFSET_W{1'b0}}};
        end else if (walking) begin
            mem_req_o.we   = 1'b1;
            mem_req_o.addr = {tag_q[cnt_q], cnt_q, {OFFSET_W{1'b0}}};
        end
    end

    a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_valid_o && !mem_ready_i |=> $stable(mem_req_o));

    a_dirty_implies_valid: assert property (@(posedge clk) disable iff (rst)
        (dirty_q & ~valid_q) == '0);

endmodule

`default_nettype wire

//--- icache/icache.sv
// read-only direct-mapped instruction cache, refills a whole line on a miss
// cpu side is a held valid level answered by a one-cycle ready pulse
`timescale 1ns/1ps
`default_nettype none

module icache
    import cache_pkg::*;
#(
    parameter int INDEX_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  cpu_req_t          req_i,
    input  logic              valid_i,
    output logic [WORD_W-1:0] rdata_o,
    output logic              ready_o,
    output logic              idle_o,
    output mem_req_t          mem_req_o,
    output logic              mem_valid_o,
    input  logic [LINE_W-1:0] mem_rdata_i,
    input  logic              mem_ready_i
);

    localparam int TAG_W  = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NSETS  = 2 ** INDEX_W;
    localparam int NBANKS = 2 ** BANK_SEL_W;
    localparam int RAM_AW = INDEX_W - BANK_SEL_W;
    localparam int DEPTH  = 2 ** RAM_AW;

    cache_state_e state_q, state_d;

    logic [TAG_W-1:0]      tag_q [NSETS];
    logic [NSETS-1:0]      valid_q;
    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    req_idx;
    logic [BANK_SEL_W-1:0] bank;
    logic [LINE_W-1:0]     bank_rdata [NBANKS];
    logic [LINE_W-1:0]     line;
    logic                  hit;
    logic                  ram_rd;
    logic                  ram_wr;

    assign req_tag = req_i.addr[ADDR_W-1 -: TAG_W];
    assign req_idx = req_i.addr[OFFSET_W +: INDEX_W];
    assign bank    = req_idx[INDEX_W-1 -: BANK_SEL_W];
    assign line    = bank_rdata[bank];
    assign hit     = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
    assign idle_o  = (state_q == st_idle);

    assign ram_rd = (state_q == st_compare);  // line ready in readin
    assign ram_wr = (state_q == st_allocate) && mem_ready_i;

    for (genvar g = 0; g < NBANKS; g++) begin : g_bank
        line_sram #(.DEPTH(DEPTH)) u_ram (
            .clk     (clk),
            .en_i    ((ram_rd || ram_wr) && (bank == BANK_SEL_W'(g))),
            .we_i    (ram_wr),
            .addr_i  (req_idx[RAM_AW-1:0]),
            .wdata_i (mem_rdata_i),
            .rdata_o (bank_rdata[g])
        );
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:     if (valid_i && !ready_o) state_d = st_compare;
            st_compare:  state_d = hit ? st_readin : st_allocate;
            st_allocate: if (mem_ready_i) state_d = st_compare;
            st_readin:   state_d = st_idle;
            default:     state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= st_idle;
            valid_q     <= '0;
            ready_o     <= 1'b0;
            mem_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            ready_o     <= (state_q == st_readin);
            mem_valid_o <= (state_q == st_allocate) && !mem_ready_i;
            if (ram_wr) valid_q[req_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_wr) tag_q[req_idx] <= req_tag;
        if (state_q == st_readin) begin
            rdata_o <= req_i.addr[OFFSET_W-1] ? line[LINE_W-1 -: WORD_W] : line[WORD_W-1:0];
        end
    end

    assign mem_req_o.addr  = {req_i.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem_req_o.we    = 1'b0;
    assign mem_req_o.wdata = '0;

    // refill request only ever comes out of a miss
    a_no_mem_in_idle: assert property (@(posedge clk) disable iff (rst)
        state_q == st_idle |-> !mem_valid_o);

endmodule

`default_nettype wire

//--- source/cache_top.sv
// cache subsystem top: icache and dcache sharing one line-wide memory port
// INDEX_W sets the number of sets in both caches
`timescale 1ns/1ps
`default_nettype none

module cache_top
    import cache_pkg::*;
#(
    parameter int INDEX_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    // instruction side
    input  cpu_req_t          ireq_i,
    input  logic              ivalid_i,
    output logic [WORD_W-1:0] irdata_o,
    output logic              iready_o,
    output logic              iidle_o,
    // data side
    input  cpu_req_t          dreq_i,
    input  logic              dvalid_i,
    output logic [WORD_W-1:0] drdata_o,
    output logic              dready_o,
    output logic              didle_o,
    // memory
    output mem_req_t          mem_req_o,
    output logic              mem_valid_o,
    input  logic [LINE_W-1:0] mem_rdata_i,
    input  logic              mem_ready_i
);

    mem_req_t          imem_req;
    mem_req_t          dmem_req;
    logic              imem_valid;
    logic              dmem_valid;
    logic              imem_ready;
    logic              dmem_ready;
    logic [LINE_W-1:0] mem_rdata;

    icache #(.INDEX_W(INDEX_W)) u_icache (
        .clk(clk), .rst(rst),
        .req_i(ireq_i), .valid_i(ivalid_i),
        .rdata_o(irdata_o), .ready_o(iready_o), .idle_o(iidle_o),
        .mem_req_o(imem_req), .mem_valid_o(imem_valid),
        .mem_rdata_i(mem_rdata), .mem_ready_i(imem_ready)
    );

    dcache #(.INDEX_W(INDEX_W)) u_dcache (
        .clk(clk), .rst(rst),
        .req_i(dreq_i), .valid_i(dvalid_i),
        .rdata_o(drdata_o), .ready_o(dready_o), .idle_o(didle_o),
        .mem_req_o(dmem_req), .mem_valid_o(dmem_valid),
        .mem_rdata_i(mem_rdata), .mem_ready_i(dmem_ready)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .ireq_i(imem_req), .dreq_i(dmem_req),
        .ivalid_i(imem_valid), .dvalid_i(dmem_valid),
        .iready_o(imem_ready), .dready_o(dmem_ready),
        .rdata_o(mem_rdata),
        .mem_req_o(mem_req_o), .mem_valid_o(mem_valid_o),
        .mem_rdata_i(mem_rdata_i), .mem_ready_i(mem_ready_i)
    );

endmodule

`default_nettype wire

//--- source/line_sram.sv
// single-port synchronous line RAM, one bank of a cache data array
// read data is registered and holds over write cycles
`timescale 1ns/1ps
`default_nettype none

module line_sram
    import cache_pkg::*;
#(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     en_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [LINE_W-1:0]        wdata_i,
    output logic [LINE_W-1:0]        rdata_o
);

    logic [LINE_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;  // rdata_o keeps last read
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
// shares one memory port between icache and dcache, data side first
// grant is held from first valid until the ready pulse, no added latency
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  mem_req_t          ireq_i,
    input  mem_req_t          dreq_i,
    input  logic              ivalid_i,
    input  logic              dvalid_i,
    output logic              iready_o,
    output logic              dready_o,
    output logic [LINE_W-1:0] rdata_o,
    output mem_req_t          mem_req_o,
    output logic              mem_valid_o,
    input  logic [LINE_W-1:0] mem_rdata_i,
    input  logic              mem_ready_i
);

    logic [1:0] grant_q;  // {dcache, icache}
    logic [1:0] sel;

    // held grant wins, otherwise pick a fresh requester this cycle
    always_comb begin
        if (grant_q != 2'b00) sel = grant_q;
        else if (dvalid_i) sel = 2'b10;
        else if (ivalid_i) sel = 2'b01;
        else sel = 2'b00;
    end

    assign mem_req_o   = sel[1] ? dreq_i : ireq_i;
    assign mem_valid_o = (sel[1] && dvalid_i) || (sel[0] && ivalid_i);
    assign iready_o    = sel[0] && mem_ready_i;
    assign dready_o    = sel[1] && mem_ready_i;
    assign rdata_o     = mem_rdata_i;  // only the granted side looks

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= 2'b00;
        end else if (mem_ready_i) begin
            grant_q <= 2'b00;  // one free cycle after each transfer
        end else if (grant_q == 2'b00) begin
            grant_q <= sel;
        end
    end

    a_one_ready: assert property (@(posedge clk) disable iff (rst)
        !(iready_o && dready_o));

    // caches must keep valid up while they own the port
    a_grant_held_valid: assert property (@(posedge clk) disable iff (rst)
        (grant_q & ~{dvalid_i, ivalid_i}) == 2'b00);

endmodule

`default_nettype wire

//--- tb/cache_checker.sv
// watches both CPU ports and the memory port of cache_top at the falling edge
// keeps a byte-accurate shadow of the data window and counts mismatches
`timescale 1ns/1ps
`default_nettype none

module cache_checker
    import cache_pkg::*;
#(
    parameter logic [ADDR_W-1:0] DBASE = 64'h0000_0000_0080_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  cpu_req_t          ireq_i,
    input  logic              ivalid_i,
    input  logic [WORD_W-1:0] irdata_i,
    input  logic              iready_i,
    input  logic              iidle_i,
    input  cpu_req_t          dreq_i,
    input  logic              dvalid_i,
    input  logic [WORD_W-1:0] drdata_i,
    input  logic              dready_i,
    input  logic              didle_i,
    input  mem_req_t          mem_req_i,
    input  logic              mem_valid_i,
    input  logic              mem_ready_i,
    output int                err_count_o,
    output int                check_count_o
);

    localparam int NLINES = 1024;

    logic [LINE_W-1:0] shadow [NLINES];
    logic [NLINES-1:0] written;   // line differs from power-on content
    logic [NLINES-1:0] dirty;     // written since its last write-back
    longint            cycle;
    longint            iacc_cycle;
    longint            dacc_cycle;
    logic [ADDR_W-1:0] ilast_addr;
    logic [ADDR_W-1:0] dlast_addr;
    logic              ilast_read;
    logic              dlast_read;
    logic              irepeat;
    logic              drepeat;
    logic              ibusy;     // accepted and not yet answered
    logic              dbusy;
    logic              seen_accept;
    logic              mem_pending;
    mem_req_t          mem_req_q;

    function automatic logic [WORD_W-1:0] init_word(input logic [ADDR_W-1:0] a);
        return a ^ {a[31:0], a[63:32]} ^ 64'h5a5a_c3c3_0f0f_9696;
    endfunction

    function automatic logic in_window(input logic [ADDR_W-1:0] a);
        return a[ADDR_W-1:14] == DBASE[ADDR_W-1:14];
    endfunction

    function automatic logic [LINE_W-1:0] expected_line(input logic [ADDR_W-1:0] la);
        if (in_window(la) && written[la[13:4]]) return shadow[la[13:4]];
        return {init_word(la + 64'd8), init_word(la)};
    endfunction

    task automatic flag_error(input string msg);
        err_count_o++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic apply_write(input cpu_req_t r);
        logic [LINE_W-1:0] line;
        logic [ADDR_W-1:0] la;
        int                base;
        la   = {r.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        base = r.addr[3] ? WORD_W : 0;
        line = expected_line(la);
        for (int b = 0; b < 8; b++) begin
            if (r.wmask[b]) line[base + b*8 +: 8] = r.wdata[b*8 +: 8];
        end
        shadow[la[13:4]]  = line;
        written[la[13:4]] = 1'b1;
        dirty[la[13:4]]   = 1'b1;
    endtask

    task automatic watch_iport();
        logic [WORD_W-1:0] exp;
        if (iidle_i !== (!ibusy || iready_i)) begin
            flag_error($sformatf("icache idle %b out of step with its request", iidle_i));
        end
        if (ivalid_i && iidle_i && !iready_i) begin
            seen_accept = 1'b1;
            ibusy       = 1'b1;
            iacc_cycle  = cycle;
            irepeat     = ilast_read && (ireq_i.addr == ilast_addr);
        end
        if (iready_i) begin
            if (!ibusy) flag_error("icache ready without an accepted request");
            ibusy = 1'b0;
            exp   = init_word({ireq_i.addr[ADDR_W-1:3], 3'b000});
            check_count_o++;
            if (irdata_i !== exp) begin
                flag_error($sformatf("ifetch %h read %h expected %h", ireq_i.addr, irdata_i, exp));
            end
            if (irepeat && cycle - iacc_cycle != 3) begin
                flag_error($sformatf("ifetch hit %h took %0d cycles", ireq_i.addr,
                                     cycle - iacc_cycle));
            end
            ilast_read = 1'b1;
            ilast_addr = ireq_i.addr;
        end
    endtask

    task automatic watch_dport();
        logic [LINE_W-1:0] line;
        logic [WORD_W-1:0] exp;
        // a write stays busy through its writein cycle
        if (didle_i !== (!dbusy || (dready_i && !dreq_i.we))) begin
            flag_error($sformatf("dcache idle %b out of step with its request", didle_i));
        end
        if (dvalid_i && didle_i && !dready_i) begin
            seen_accept = 1'b1;
            dbusy       = 1'b1;
            dacc_cycle  = cycle;
            drepeat     = dlast_read && !dreq_i.we && !dreq_i.fence && (dreq_i.addr == dlast_addr);
        end
        if (dready_i) begin
            if (!dbusy) flag_error("dcache ready without an accepted request");
            dbusy      = 1'b0;
            dlast_read = 1'b0;
            if (dreq_i.fence) begin
                check_count_o++;
                if (dirty != '0) flag_error("fence done with lines still dirty");
            end else if (dreq_i.we) begin
                apply_write(dreq_i);
            end else begin
                line = expected_line({dreq_i.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
                exp  = dreq_i.addr[3] ? line[LINE_W-1 -: WORD_W] : line[WORD_W-1:0];
                check_count_o++;
                if (drdata_i !== exp) begin
                    flag_error($sformatf("load %h read %h expected %h",
                                         dreq_i.addr, drdata_i, exp));
                end
                if (drepeat && cycle - dacc_cycle != 3) begin
                    flag_error($sformatf("load hit %h took %0d cycles", dreq_i.addr,
                                         cycle - dacc_cycle));
                end
                dlast_read = 1'b1;
                dlast_addr = dreq_i.addr;
            end
        end
    endtask

    task automatic watch_mport();
        logic [ADDR_W-1:0] la;
        if (mem_pending && (!mem_valid_i || mem_req_i !== mem_req_q)) begin
            flag_error("memory request changed before ready");
        end
        if (mem_valid_i && !seen_accept) flag_error("memory request before any CPU request");
        if (mem_valid_i && iidle_i && didle_i) flag_error("memory request with both caches idle");
        if (mem_valid_i && mem_ready_i && mem_req_i.we) begin
            la = mem_req_i.addr;
            check_count_o++;
            if (!in_window(la)) begin
                flag_error($sformatf("write-back to %h outside the data window", la));
            end else if (!dirty[la[13:4]]) begin
                flag_error($sformatf("write-back of %h not written since last write-back", la));
            end else if (mem_req_i.wdata !== expected_line(la)) begin
                flag_error($sformatf("write-back %h line %h expected %h", la,
                                     mem_req_i.wdata, expected_line(la)));
            end
            if (in_window(la)) dirty[la[13:4]] = 1'b0;
        end
        mem_pending = mem_valid_i && !mem_ready_i;
        mem_req_q   = mem_req_i;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            err_count_o   = 0;
            check_count_o = 0;
            written       = '0;
            dirty         = '0;
            cycle         = 0;
            ilast_read    = 1'b0;
            dlast_read    = 1'b0;
            irepeat       = 1'b0;
            drepeat       = 1'b0;
            ibusy         = 1'b0;
            dbusy         = 1'b0;
            seen_accept   = 1'b0;
            mem_pending   = 1'b0;
        end else begin
            cycle++;
            watch_iport();
            watch_dport();
            watch_mport();
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_cache_top.sv
// random instruction and data traffic into cache_top with a line memory model behind it
// cache_checker compares the responses and keeps the error count
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top
    import cache_pkg::*;
();

    localparam logic [ADDR_W-1:0] IBASE = 64'h0000_0000_0040_0000;
    localparam logic [ADDR_W-1:0] DBASE = 64'h0000_0000_0080_0000;
    localparam int NLINES      = 1024;   // 16 KB data window
    localparam int REQ_TIMEOUT = 20000;  // fence walk with many dirty lines

    logic              clk;
    logic              rst;
    cpu_req_t          ireq;
    logic              ivalid;
    logic [WORD_W-1:0] irdata;
    logic              iready;
    logic              iidle;
    cpu_req_t          dreq;
    logic              dvalid;
    logic [WORD_W-1:0] drdata;
    logic              dready;
    logic              didle;
    mem_req_t          mem_req;
    logic              mem_valid;
    logic [LINE_W-1:0] mem_rdata;
    logic              mem_ready;

    integer            seed;
    int                timeouts;
    int                err_count;
    int                check_count;
    logic              ihung;
    logic              dhung;
    logic [LINE_W-1:0] dmem [NLINES];
    logic [NLINES-1:0] dmem_written;

    cache_top #(.INDEX_W(8)) dut (
        .clk(clk), .rst(rst),
        .ireq_i(ireq), .ivalid_i(ivalid), .irdata_o(irdata), .iready_o(iready), .iidle_o(iidle),
        .dreq_i(dreq), .dvalid_i(dvalid), .drdata_o(drdata), .dready_o(dready), .didle_o(didle),
        .mem_req_o(mem_req), .mem_valid_o(mem_valid),
        .mem_rdata_i(mem_rdata), .mem_ready_i(mem_ready)
    );

    cache_checker #(.DBASE(DBASE)) u_check (
        .clk(clk), .rst(rst),
        .ireq_i(ireq), .ivalid_i(ivalid), .irdata_i(irdata), .iready_i(iready), .iidle_i(iidle),
        .dreq_i(dreq), .dvalid_i(dvalid), .drdata_i(drdata), .dready_i(dready), .didle_i(didle),
        .mem_req_i(mem_req), .mem_valid_i(mem_valid), .mem_ready_i(mem_ready),
        .err_count_o(err_count), .check_count_o(check_count)
    );

    // power-on content of every line depends on its full address
    function automatic logic [WORD_W-1:0] init_word(input logic [ADDR_W-1:0] a);
        return a ^ {a[31:0], a[63:32]} ^ 64'h5a5a_c3c3_0f0f_9696;
    endfunction

    function automatic logic [LINE_W-1:0] read_line(input logic [ADDR_W-1:0] la);
        if (la[ADDR_W-1:14] == DBASE[ADDR_W-1:14] && dmem_written[la[13:4]]) begin
            return dmem[la[13:4]];
        end
        return {init_word(la + 64'd8), init_word(la)};
    endfunction

    task automatic issue_ireq(input cpu_req_t r);
        int waited;
        ireq   = r;
        ivalid = 1'b1;
        waited = 0;
        while (!iready && waited < REQ_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!iready) begin
            $display("timeout: instruction port got no ready within %0d cycles, addr %h",
                     REQ_TIMEOUT, r.addr);
            timeouts++;
            ihung = 1'b1;
        end
        @(posedge clk);  // valid stays up through the ready cycle
        #1;
        ivalid = 1'b0;
        repeat (1 + ($random(seed) & 3)) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issue_dreq(input cpu_req_t r);
        int waited;
        dreq   = r;
        dvalid = 1'b1;
        waited = 0;
        while (!dready && waited < REQ_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!dready) begin
            $display("timeout: data port got no ready within %0d cycles, addr %h fence %0d",
                     REQ_TIMEOUT, r.addr, r.fence);
            timeouts++;
            dhung = 1'b1;
        end
        @(posedge clk);
        #1;
        dvalid = 1'b0;
        repeat (1 + ($random(seed) & 3)) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_istream(input int n);
        cpu_req_t          r;
        logic [ADDR_W-1:0] last;
        last = IBASE;
        for (int i = 0; i < n && !ihung; i++) begin
            r = '0;
            if (i > 0 && ($random(seed) & 3) == 0) r.addr = last;  // repeat must hit
            else r.addr = IBASE | ($random(seed) & 32'h3ff8);
            issue_ireq(r);
            last = r.addr;
        end
    endtask

    task automatic run_dstream(input int n);
        cpu_req_t          r;
        logic [ADDR_W-1:0] last;
        logic              last_read;
        int                kind;
        last      = DBASE;
        last_read = 1'b0;
        for (int i = 0; i < n && !dhung; i++) begin
            r    = '0;
            kind = $random(seed) & 31;
            if (kind == 0) begin
                r.fence = 1'b1;
            end else if (last_read && kind < 8) begin
                r.addr = last;
            end else begin
                r.addr = DBASE | ($random(seed) & 32'h3ff8);
                if (kind < 20) begin
                    r.we    = 1'b1;
                    r.wdata = {$random(seed), $random(seed)};
                    r.wmask = 8'($random(seed));
                    if (r.wmask == 8'h00) r.wmask = 8'h81;
                end
            end
            issue_dreq(r);
            last_read = !r.we && !r.fence;
            last      = r.addr;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory port model answers after 1 to 8 cycles
    initial begin : mem_responder
        int   delay;
        logic busy;
        busy  = 1'b0;
        delay = 0;
        forever begin
            @(posedge clk);
            #1;
            mem_ready = 1'b0;
            if (rst || !mem_valid) begin
                busy = 1'b0;
            end else if (!busy) begin
                busy  = 1'b1;
                delay = 1 + ($random(seed) & 7);
            end else begin
                delay--;
                if (delay == 0) begin
                    busy      = 1'b0;
                    mem_ready = 1'b1;
                    if (!mem_req.we) begin
                        mem_rdata = read_line(mem_req.addr);
                    end else if (mem_req.addr[ADDR_W-1:14] == DBASE[ADDR_W-1:14]) begin
                        dmem[mem_req.addr[13:4]]         = mem_req.wdata;
                        dmem_written[mem_req.addr[13:4]] = 1'b1;
                    end
                end
            end
        end
    end

    initial begin : main_flow
        cpu_req_t fence_req;
        seed         = 32'hdd21336a;
        rst          = 1'b1;
        ireq         = '0;
        ivalid       = 1'b0;
        dreq         = '0;
        dvalid       = 1'b0;
        mem_ready    = 1'b0;
        mem_rdata    = '0;
        dmem_written = '0;
        timeouts     = 0;
        ihung        = 1'b0;
        dhung        = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            run_istream(400);
            run_dstream(600);
        join
        if (!dhung) begin
            fence_req       = '0;
            fence_req.fence = 1'b1;
            issue_dreq(fence_req);  // every written line goes back to memory
        end
        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/cache_pkg.sv
source/line_sram.sv
icache/icache.sv
dcache/dcache.sv
source/mem_arbiter.sv
source/cache_top.sv
tb/cache_checker.sv
tb/tb_cache_top.sv
